// File: build.f
fp_format_pkg.sv
fp_op_pkg.sv
fp_pre_stage_ctrl.sv
fp_operand_classify.sv
fp_add_order.sv
fp_misc_operands.sv
fp_pre_processing.sv
fp_pre_checker.sv
tb_fp_pre_processing.sv

// File: fp_add_order.sv
/*
 * Adder operand ordering: puts the larger magnitude first and registers
 * the ordered words, their classes, the exponent gap and effective subtract.
 */
module fp_add_order (
    input  logic                                  clk,
    input  logic                                  i_load,
    input  logic [fp_op_pkg::OP_WIDTH-1:0]        i_op,
    input  fp_format_pkg::fp_word_t               i_rs1,
    input  fp_format_pkg::fp_word_t               i_rs2,
    input  logic [fp_format_pkg::CLASS_WIDTH-1:0] i_rs1_class,
    input  logic [fp_format_pkg::CLASS_WIDTH-1:0] i_rs2_class,
    input  logic                                  i_rs1_subnormal,
    input  logic                                  i_rs2_subnormal,
    output fp_format_pkg::fp_word_t               o_rs1,
    output fp_format_pkg::fp_word_t               o_rs2,
    output logic [fp_format_pkg::CLASS_WIDTH-1:0] o_rs1_class,
    output logic [fp_format_pkg::CLASS_WIDTH-1:0] o_rs2_class,
    output logic                                  o_swap,
    output logic [fp_format_pkg::EXPO_WIDTH-1:0]  o_expo_diff,
    output logic                                  o_eff_sub
);

    localparam int EW = fp_format_pkg::EXPO_WIDTH;
    localparam int FW = fp_format_pkg::FRAC_WIDTH;

    logic [EW-1:0] rs1_expo;
    logic [EW-1:0] rs2_expo;
    logic [EW+FW:0] rs1_mag;
    logic [EW+FW:0] rs2_mag;
    logic          swap;
    logic [EW-1:0] expo_diff;
    logic          eff_sub;

    // Subnormals sit at exponent 1 without the hidden bit
    assign rs1_expo = i_rs1_subnormal ? EW'(1) : i_rs1.f.expo;
    assign rs2_expo = i_rs2_subnormal ? EW'(1) : i_rs2.f.expo;

    // Effective exponent, hidden bit, fraction
    assign rs1_mag = {rs1_expo, ~i_rs1_subnormal, i_rs1.f.frac};
    assign rs2_mag = {rs2_expo, ~i_rs2_subnormal, i_rs2.f.frac};

    assign swap      = rs2_mag > rs1_mag;
    assign expo_diff = swap ? (rs2_expo - rs1_expo) : (rs1_expo - rs2_expo);

    // Sign mismatch subtracts, OP_SUB flips it
    assign eff_sub = i_rs1.f.sign ^ i_rs2.f.sign ^ (i_op == fp_op_pkg::OP_SUB);

    always_ff @(posedge clk) begin
        if (i_load) begin
            o_rs1       <= swap ? i_rs2 : i_rs1;
            o_rs2       <= swap ? i_rs1 : i_rs2;
            o_rs1_class <= swap ? i_rs2_class : i_rs1_class;
            o_rs2_class <= swap ? i_rs1_class : i_rs2_class;
            o_swap      <= swap;
            o_expo_diff <= expo_diff;
            o_eff_sub   <= eff_sub;
        end
    end

endmodule

// File: fp_format_pkg.sv
/*
 * Single-precision format definitions shared by the pre-processing stage.
 * Field widths, class flag positions and the operand word type.
 */
package fp_format_pkg;

    localparam int FLEN       = 32;
    localparam int EXPO_WIDTH = 8;
    localparam int FRAC_WIDTH = 23;
    localparam int BIAS       = 127;

    // Quiet NaN, positive sign, top fraction bit set
    localparam logic [FLEN-1:0] CANONICAL_NAN =
        {1'b0, {EXPO_WIDTH{1'b1}}, 1'b1, {(FRAC_WIDTH-1){1'b0}}};

    ////////////////////
    // Class flag vector
    localparam int CLASS_WIDTH = 4;
    localparam int CLASS_INF   = 3;
    localparam int CLASS_SNAN  = 2;
    localparam int CLASS_QNAN  = 1;
    localparam int CLASS_ZERO  = 0;

    ////////////////////
    // Operand word, read as float fields or as a plain integer
    typedef union packed {
        struct packed {
            logic                  sign;
            logic [EXPO_WIDTH-1:0] expo;
            logic [FRAC_WIDTH-1:0] frac;
        } f;
        logic [FLEN-1:0] word;
    } fp_word_t;

endpackage

// File: fp_misc_operands.sv
/*
 * Sign injection, min/max selection and integer-to-float operand prep.
 * Results are computed from the live inputs and captured on the load strobe.
 */
module fp_misc_operands #(
    parameter int XLEN = 32
) (
    input  logic                                  clk,
    input  logic                                  i_load,
    input  logic [fp_op_pkg::OP_WIDTH-1:0]        i_op,
    input  logic [fp_op_pkg::RM_WIDTH-1:0]        i_rm,
    input  fp_format_pkg::fp_word_t               i_rs1,
    input  fp_format_pkg::fp_word_t               i_rs2,
    input  logic [fp_format_pkg::CLASS_WIDTH-1:0] i_rs1_class,
    input  logic [fp_format_pkg::CLASS_WIDTH-1:0] i_rs2_class,
    output fp_format_pkg::fp_word_t               o_result,
    output logic                                  o_invalid,
    output logic [XLEN-1:0]                       o_int_abs,
    output logic                                  o_int_sign,
    output logic                                  o_int_zero
);

    localparam int FLEN = fp_format_pkg::FLEN;

    logic                    sgnj_sign;
    logic                    rs1_nan;
    logic                    rs2_nan;
    logic                    rs1_snan;
    logic                    rs2_snan;
    logic                    rs1_less;
    logic                    take_rs2;
    fp_format_pkg::fp_word_t result;
    logic                    invalid;
    logic [XLEN-1:0]         int_src;
    logic [XLEN-1:0]         int_abs;
    logic                    int_sign;

    ////////////////////
    // Sign injection
    always_comb begin
        case (i_rm[1:0])
            fp_op_pkg::SGNJ_JN: sgnj_sign = ~i_rs2.f.sign;
            fp_op_pkg::SGNJ_JX: sgnj_sign = i_rs1.f.sign ^ i_rs2.f.sign;
            // SGNJ_J and the unused encoding
            default:            sgnj_sign = i_rs2.f.sign;
        endcase
    end

    ////////////////////
    // Min/max
    assign rs1_snan = i_rs1_class[fp_format_pkg::CLASS_SNAN];
    assign rs2_snan = i_rs2_class[fp_format_pkg::CLASS_SNAN];
    assign rs1_nan  = rs1_snan | i_rs1_class[fp_format_pkg::CLASS_QNAN];
    assign rs2_nan  = rs2_snan | i_rs2_class[fp_format_pkg::CLASS_QNAN];

    // Ordering on sign and magnitude, -0 falls below +0
    always_comb begin
        if (i_rs1.f.sign != i_rs2.f.sign) begin
            rs1_less = i_rs1.f.sign;
        end else if (i_rs1.f.sign) begin
            rs1_less = i_rs2.word[FLEN-2:0] < i_rs1.word[FLEN-2:0];
        end else begin
            rs1_less = i_rs1.word[FLEN-2:0] < i_rs2.word[FLEN-2:0];
        end
    end

    assign take_rs2 = i_rm[fp_op_pkg::MINMAX_MAX_BIT] ? rs1_less : ~rs1_less;

    always_comb begin
        result  = '0;
        invalid = 1'b0;
        case (i_op)
            fp_op_pkg::OP_SGNJ: begin
                result        = i_rs1;
                result.f.sign = sgnj_sign;
            end
            fp_op_pkg::OP_MINMAX: begin
                invalid = rs1_snan | rs2_snan;
                if (rs1_nan && rs2_nan) begin
                    result.word = fp_format_pkg::CANONICAL_NAN;
                end else if (rs1_nan || (!rs2_nan && take_rs2)) begin
                    result = i_rs2;
                end else begin
                    result = i_rs1;
                end
            end
            default: begin
            end
        endcase
    end

    ////////////////////
    // Integer source, low XLEN bits of rs1
    assign int_src  = i_rs1.word[XLEN-1:0];
    assign int_sign = (i_op == fp_op_pkg::OP_I2F_S) & int_src[XLEN-1];
    assign int_abs  = int_sign ? (~int_src + XLEN'(1)) : int_src;

    always_ff @(posedge clk) begin
        if (i_load) begin
            o_result   <= result;
            o_invalid  <= invalid;
            o_int_abs  <= int_abs;
            o_int_sign <= int_sign;
            o_int_zero <= ~|int_src;
        end
    end

    // Min/max never hands out a signalling NaN
    a_minmax_quiet: assert property (
        @(posedge clk)
        (i_load && i_op == fp_op_pkg::OP_MINMAX) |=>
            !(&o_result.f.expo && |o_result.f.frac
              && !o_result.f.frac[fp_format_pkg::FRAC_WIDTH-1])
    );

endmodule

// File: fp_op_pkg.sv
/*
 * Operation codes and rounding-mode field encodings for the stage.
 * The rm field selects the sign-injection and min/max variants.
 */
package fp_op_pkg;

    localparam int OP_WIDTH = 3;
    localparam int RM_WIDTH = 3;

    ////////////////////
    // Operation codes
    localparam logic [OP_WIDTH-1:0] OP_ADD    = 3'd0;
    localparam logic [OP_WIDTH-1:0] OP_SUB    = 3'd1;
    localparam logic [OP_WIDTH-1:0] OP_SGNJ   = 3'd2;
    localparam logic [OP_WIDTH-1:0] OP_MINMAX = 3'd3;
    localparam logic [OP_WIDTH-1:0] OP_I2F_S  = 3'd4;
    localparam logic [OP_WIDTH-1:0] OP_I2F_U  = 3'd5;

    ////////////////////
    // Sign injection, held in rm[1:0]
    localparam logic [1:0] SGNJ_J  = 2'b00;
    localparam logic [1:0] SGNJ_JN = 2'b01;
    localparam logic [1:0] SGNJ_JX = 2'b10;

    // Min/max, rm bit set selects max
    localparam int MINMAX_MAX_BIT = 0;

endpackage

// File: fp_operand_classify.sv
/*
 * Special-case and subnormal detection for one single-precision operand.
 * Purely combinational; one instance per source operand.
 */
module fp_operand_classify (
    input  fp_format_pkg::fp_word_t                 i_rs,
    output logic [fp_format_pkg::CLASS_WIDTH-1:0]   o_class,
    output logic                                    o_subnormal
);

    logic expo_ones;
    logic expo_zero;
    logic frac_zero;
    logic frac_msb;

    assign expo_ones = &i_rs.f.expo;
    assign expo_zero = ~|i_rs.f.expo;
    assign frac_zero = ~|i_rs.f.frac;

    // Quiet bit of a NaN
    assign frac_msb = i_rs.f.frac[fp_format_pkg::FRAC_WIDTH-1];

    always_comb begin
        o_class = '0;
        o_class[fp_format_pkg::CLASS_INF]  = expo_ones & frac_zero;
        o_class[fp_format_pkg::CLASS_SNAN] = expo_ones & ~frac_zero & ~frac_msb;
        o_class[fp_format_pkg::CLASS_QNAN] = expo_ones & frac_msb;
        o_class[fp_format_pkg::CLASS_ZERO] = expo_zero & frac_zero;
    end

    // Zero exponent with something in the fraction
    assign o_subnormal = expo_zero & ~frac_zero;

endmodule

// File: fp_pre_checker.sv
/*
 * Watches the pre-processing stage ports, predicts each result packet
 * and compares it on every output transfer and while the output stalls.
 */
module fp_pre_checker #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            i_rst,
    input  logic            i_in_valid,
    input  logic            i_in_ready,
    input  logic [2:0]      i_in_op,
    input  logic [2:0]      i_in_rm,
    input  logic [31:0]     i_in_rs1,
    input  logic [31:0]     i_in_rs2,
    input  logic            i_out_valid,
    input  logic            i_out_ready,
    input  logic [2:0]      i_out_op,
    input  logic [31:0]     i_out_rs1,
    input  logic [31:0]     i_out_rs2,
    input  logic [3:0]      i_out_rs1_class,
    input  logic [3:0]      i_out_rs2_class,
    input  logic            i_out_swap,
    input  logic [7:0]      i_out_expo_diff,
    input  logic            i_out_eff_sub,
    input  logic [31:0]     i_out_result,
    input  logic            i_out_invalid,
    input  logic [XLEN-1:0] i_out_int_abs,
    input  logic            i_out_int_sign,
    input  logic            i_out_int_zero,
    output int              o_inputs,
    output int              o_outputs,
    output int              o_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [2:0]      op;
        logic [31:0]     rs1;
        logic [31:0]     rs2;
        logic [3:0]      rs1_class;
        logic [3:0]      rs2_class;
        logic            swap;
        logic [7:0]      expo_diff;
        logic            eff_sub;
        logic [31:0]     result;
        logic            invalid;
        logic [XLEN-1:0] int_abs;
        logic            int_sign;
        logic            int_zero;
    } packet_t;

    packet_t expect_q[$];
    packet_t seen;
    packet_t held;
    packet_t want;
    logic    stalled;
    logic    rst_q;
    int      bad;

    assign seen = {i_out_op, i_out_rs1, i_out_rs2, i_out_rs1_class, i_out_rs2_class,
                   i_out_swap, i_out_expo_diff, i_out_eff_sub, i_out_result,
                   i_out_invalid, i_out_int_abs, i_out_int_sign, i_out_int_zero};

    function automatic logic [3:0] class_of(input logic [31:0] w);
        logic [3:0] c;
        c = '0;
        c[fp_format_pkg::CLASS_INF]  = (w[30:23] == 8'hff) && (w[22:0] == 0);
        c[fp_format_pkg::CLASS_SNAN] = (w[30:23] == 8'hff) && (w[22:0] != 0) && !w[22];
        c[fp_format_pkg::CLASS_QNAN] = (w[30:23] == 8'hff) && w[22];
        c[fp_format_pkg::CLASS_ZERO] = (w[30:0] == 0);
        return c;
    endfunction

    // Unsigned scale that follows float order, -0 just below +0
    function automatic logic [31:0] order_key(input logic [31:0] w);
        return w[31] ? ~w : {1'b1, w[30:0]};
    endfunction

    function automatic packet_t expected_packet(input logic [2:0] op, input logic [2:0] rm,
                                                input logic [31:0] a, input logic [31:0] b);
        packet_t         p;
        logic [7:0]      ea;
        logic [7:0]      eb;
        logic [23:0]     ma;
        logic [23:0]     mb;
        logic [3:0]      ca;
        logic [3:0]      cb;
        logic [XLEN-1:0] src;
        p = '0;
        p.op = op;
        ca = class_of(a);
        cb = class_of(b);
        // Subnormals count at exponent 1 without the hidden bit
        ea = (a[30:23] == 0 && a[22:0] != 0) ? 8'd1 : a[30:23];
        eb = (b[30:23] == 0 && b[22:0] != 0) ? 8'd1 : b[30:23];
        ma = {a[30:23] != 0, a[22:0]};
        mb = {b[30:23] != 0, b[22:0]};
        p.swap = (eb > ea) || (eb == ea && mb > ma);
        p.rs1 = p.swap ? b : a;
        p.rs2 = p.swap ? a : b;
        p.rs1_class = p.swap ? cb : ca;
        p.rs2_class = p.swap ? ca : cb;
        p.expo_diff = p.swap ? eb - ea : ea - eb;
        p.eff_sub = a[31] ^ b[31] ^ (op == fp_op_pkg::OP_SUB);
        if (op == fp_op_pkg::OP_SGNJ) begin
            case (rm[1:0])
                fp_op_pkg::SGNJ_JN: p.result = {~b[31], a[30:0]};
                fp_op_pkg::SGNJ_JX: p.result = {a[31] ^ b[31], a[30:0]};
                default:            p.result = {b[31], a[30:0]};
            endcase
        end else if (op == fp_op_pkg::OP_MINMAX) begin
            p.invalid = ca[fp_format_pkg::CLASS_SNAN] | cb[fp_format_pkg::CLASS_SNAN];
            if (ca[2:1] != 0 && cb[2:1] != 0) begin
                p.result = fp_format_pkg::CANONICAL_NAN;
            end else if (ca[2:1] != 0) begin
                p.result = b;
            end else if (cb[2:1] != 0) begin
                p.result = a;
            end else if (rm[fp_op_pkg::MINMAX_MAX_BIT]) begin
                p.result = (order_key(b) > order_key(a)) ? b : a;
            end else begin
                p.result = (order_key(b) < order_key(a)) ? b : a;
            end
        end
        src = a[XLEN-1:0];
        p.int_sign = (op == fp_op_pkg::OP_I2F_S) && src[XLEN-1];
        p.int_abs = p.int_sign ? -src : src;
        p.int_zero = (src == 0);
        return p;
    endfunction

    task automatic check_field(input string name, input logic [63:0] exp_val,
                               input logic [63:0] got_val, input string what, inout int errs);
        if (exp_val !== got_val) begin
            $display("ERROR at %0t: %s expected %0h got %0h%s",
                     $time, name, exp_val, got_val, what);
            errs++;
        end
    endtask

    task automatic compare_packet(input packet_t w, input packet_t g, input string what,
                                  inout int errs);
        check_field("o_op", w.op, g.op, what, errs);
        check_field("o_rs1", w.rs1, g.rs1, what, errs);
        check_field("o_rs2", w.rs2, g.rs2, what, errs);
        check_field("o_rs1_class", w.rs1_class, g.rs1_class, what, errs);
        check_field("o_rs2_class", w.rs2_class, g.rs2_class, what, errs);
        check_field("o_swap", w.swap, g.swap, what, errs);
        check_field("o_expo_diff", w.expo_diff, g.expo_diff, what, errs);
        check_field("o_eff_sub", w.eff_sub, g.eff_sub, what, errs);
        check_field("o_result", w.result, g.result, what, errs);
        check_field("o_invalid", w.invalid, g.invalid, what, errs);
        check_field("o_int_abs", w.int_abs, g.int_abs, what, errs);
        check_field("o_int_sign", w.int_sign, g.int_sign, what, errs);
        check_field("o_int_zero", w.int_zero, g.int_zero, what, errs);
    endtask

    always @(posedge clk) begin
        if (i_rst) begin
            rst_q = 1'b1;
            stalled = 1'b0;
            o_inputs = 0;
            o_outputs = 0;
            o_errors = 0;
        end else begin
            // First edge out of reset sees an empty stage
            if (rst_q) begin
                check_field("o_valid", 1'b0, i_out_valid, "", o_errors);
                check_field("o_ready", 1'b1, i_in_ready, "", o_errors);
            end
            rst_q = 1'b0;
            if (stalled) begin
                compare_packet(held, seen, " while stalled", o_errors);
            end
            if (i_out_valid && i_out_ready) begin
                if (expect_q.size() == 0) begin
                    $display("Output transfer at %0t came with no accepted input", $time);
                    o_errors++;
                end else begin
                    want = expect_q.pop_front();
                    bad = 0;
                    compare_packet(want, seen, "", bad);
                    o_errors += bad;
                    o_outputs++;
                    $display("Op %0d (code %0d) %s", o_outputs, want.op,
                             (bad == 0) ? "ok" : "mismatch");
                end
            end
            if (i_in_valid && i_in_ready) begin
                expect_q.push_back(expected_packet(i_in_op, i_in_rm, i_in_rs1, i_in_rs2));
                o_inputs++;
            end
            stalled = i_out_valid && !i_out_ready;
            held = seen;
        end
    end

endmodule

// File: fp_pre_processing.sv
/*
 * Floating-point operand pre-processing stage, single precision.
 * One op per valid/ready transfer, registered result packet one cycle later.
 */
module fp_pre_processing #(
    parameter int XLEN = 32
) (
    input  logic                                  clk,
    input  logic                                  i_rst,
    input  logic                                  i_valid,
    output logic                                  o_ready,
    input  logic [fp_op_pkg::OP_WIDTH-1:0]        i_op,
    input  logic [fp_op_pkg::RM_WIDTH-1:0]        i_rm,
    input  fp_format_pkg::fp_word_t               i_rs1,
    input  fp_format_pkg::fp_word_t               i_rs2,
    output logic                                  o_valid,
    input  logic                                  i_ready,
    output logic [fp_op_pkg::OP_WIDTH-1:0]        o_op,
    output fp_format_pkg::fp_word_t               o_rs1,
    output fp_format_pkg::fp_word_t               o_rs2,
    output logic [fp_format_pkg::CLASS_WIDTH-1:0] o_rs1_class,
    output logic [fp_format_pkg::CLASS_WIDTH-1:0] o_rs2_class,
    output logic                                  o_swap,
    output logic [fp_format_pkg::EXPO_WIDTH-1:0]  o_expo_diff,
    output logic                                  o_eff_sub,
    output fp_format_pkg::fp_word_t               o_result,
    output logic                                  o_invalid,
    output logic [XLEN-1:0]                       o_int_abs,
    output logic                                  o_int_sign,
    output logic                                  o_int_zero
);

    logic                                  load;
    logic [fp_format_pkg::CLASS_WIDTH-1:0] rs1_class;
    logic [fp_format_pkg::CLASS_WIDTH-1:0] rs2_class;
    logic                                  rs1_subnormal;
    logic                                  rs2_subnormal;

    ////////////////////
    // Control
    fp_pre_stage_ctrl u_ctrl (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_valid (i_valid),
        .i_ready (i_ready),
        .i_op    (i_op),
        .o_ready (o_ready),
        .o_load  (load),
        .o_valid (o_valid),
        .o_op    (o_op)
    );

    ////////////////////
    // Classification
    fp_operand_classify u_rs1_classify (
        .i_rs        (i_rs1),
        .o_class     (rs1_class),
        .o_subnormal (rs1_subnormal)
    );

    fp_operand_classify u_rs2_classify (
        .i_rs        (i_rs2),
        .o_class     (rs2_class),
        .o_subnormal (rs2_subnormal)
    );

    ////////////////////
    // Datapath
    fp_add_order u_add_order (
        .clk             (clk),
        .i_load          (load),
        .i_op            (i_op),
        .i_rs1           (i_rs1),
        .i_rs2           (i_rs2),
        .i_rs1_class     (rs1_class),
        .i_rs2_class     (rs2_class),
        .i_rs1_subnormal (rs1_subnormal),
        .i_rs2_subnormal (rs2_subnormal),
        .o_rs1           (o_rs1),
        .o_rs2           (o_rs2),
        .o_rs1_class     (o_rs1_class),
        .o_rs2_class     (o_rs2_class),
        .o_swap          (o_swap),
        .o_expo_diff     (o_expo_diff),
        .o_eff_sub       (o_eff_sub)
    );

    fp_misc_operands #(
        .XLEN (XLEN)
    ) u_misc_operands (
        .clk         (clk),
        .i_load      (load),
        .i_op        (i_op),
        .i_rm        (i_rm),
        .i_rs1       (i_rs1),
        .i_rs2       (i_rs2),
        .i_rs1_class (rs1_class),
        .i_rs2_class (rs2_class),
        .o_result    (o_result),
        .o_invalid   (o_invalid),
        .o_int_abs   (o_int_abs),
        .o_int_sign  (o_int_sign),
        .o_int_zero  (o_int_zero)
    );

endmodule

// File: fp_pre_stage_ctrl.sv
/*
 * Handshake control for the single register stage.
 * Holds the valid bit, forms ready and the load strobe, keeps the op code.
 */
module fp_pre_stage_ctrl (
    input  logic                          clk,
    input  logic                          i_rst,
    input  logic                          i_valid,
    input  logic                          i_ready,
    input  logic [fp_op_pkg::OP_WIDTH-1:0] i_op,
    output logic                          o_ready,
    output logic                          o_load,
    output logic                          o_valid,
    output logic [fp_op_pkg::OP_WIDTH-1:0] o_op
);

    logic                           stage_valid;
    logic [fp_op_pkg::OP_WIDTH-1:0] op_q;

    // Accept when empty or when the held result leaves this cycle
    assign o_ready = ~stage_valid | i_ready;
    assign o_load  = i_valid & o_ready;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            stage_valid <= 1'b0;
        end else if (o_ready) begin
            stage_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (o_load) begin
            op_q <= i_op;
        end
    end

    assign o_valid = stage_valid;
    assign o_op    = op_q;

    ////////////////////
    // Handshake checks

    // Held packet may not change while the consumer stalls
    a_op_hold: assert property (
        @(posedge clk) disable iff (i_rst)
        (o_valid && !i_ready) |=> $stable(o_op)
    );

    // A stalled result stays valid until the consumer takes it
    a_valid_hold: assert property (
        @(posedge clk) disable iff (i_rst)
        (o_valid && !i_ready) |=> o_valid
    );

endmodule

// File: tb_fp_pre_processing.sv
/*
 * Testbench for the pre-processing stage. Random operations with special
 * operands and random back-pressure; fp_pre_checker does the comparing.
 */
module tb_fp_pre_processing;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int XLEN           = 32;
    localparam int NUM_OPS        = 300;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * NUM_OPS + 50;

    logic                    clk;
    logic                    i_rst;
    logic                    i_valid;
    logic                    o_ready;
    logic [2:0]              i_op;
    logic [2:0]              i_rm;
    fp_format_pkg::fp_word_t i_rs1;
    fp_format_pkg::fp_word_t i_rs2;
    logic                    o_valid;
    logic                    i_ready;
    logic [2:0]              o_op;
    fp_format_pkg::fp_word_t o_rs1;
    fp_format_pkg::fp_word_t o_rs2;
    logic [3:0]              o_rs1_class;
    logic [3:0]              o_rs2_class;
    logic                    o_swap;
    logic [7:0]              o_expo_diff;
    logic                    o_eff_sub;
    fp_format_pkg::fp_word_t o_result;
    logic                    o_invalid;
    logic [XLEN-1:0]         o_int_abs;
    logic                    o_int_sign;
    logic                    o_int_zero;

    logic [31:0] lfsr;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic        took;
    int          sent;
    int          cycles;
    int          inputs;
    int          outputs;
    int          errors;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    fp_pre_processing #(
        .XLEN (XLEN)
    ) DUT (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_valid     (i_valid),
        .o_ready     (o_ready),
        .i_op        (i_op),
        .i_rm        (i_rm),
        .i_rs1       (i_rs1),
        .i_rs2       (i_rs2),
        .o_valid     (o_valid),
        .i_ready     (i_ready),
        .o_op        (o_op),
        .o_rs1       (o_rs1),
        .o_rs2       (o_rs2),
        .o_rs1_class (o_rs1_class),
        .o_rs2_class (o_rs2_class),
        .o_swap      (o_swap),
        .o_expo_diff (o_expo_diff),
        .o_eff_sub   (o_eff_sub),
        .o_result    (o_result),
        .o_invalid   (o_invalid),
        .o_int_abs   (o_int_abs),
        .o_int_sign  (o_int_sign),
        .o_int_zero  (o_int_zero)
    );

    fp_pre_checker #(
        .XLEN (XLEN)
    ) u_checker (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_in_valid      (i_valid),
        .i_in_ready      (o_ready),
        .i_in_op         (i_op),
        .i_in_rm         (i_rm),
        .i_in_rs1        (i_rs1),
        .i_in_rs2        (i_rs2),
        .i_out_valid     (o_valid),
        .i_out_ready     (i_ready),
        .i_out_op        (o_op),
        .i_out_rs1       (o_rs1),
        .i_out_rs2       (o_rs2),
        .i_out_rs1_class (o_rs1_class),
        .i_out_rs2_class (o_rs2_class),
        .i_out_swap      (o_swap),
        .i_out_expo_diff (o_expo_diff),
        .i_out_eff_sub   (o_eff_sub),
        .i_out_result    (o_result),
        .i_out_invalid   (o_invalid),
        .i_out_int_abs   (o_int_abs),
        .i_out_int_sign  (o_int_sign),
        .i_out_int_zero  (o_int_zero),
        .o_inputs        (inputs),
        .o_outputs       (outputs),
        .o_errors        (errors)
    );

    ////////////////////
    // Stimulus source

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic make_operand(output logic [31:0] w);
        logic [31:0] pick;
        logic [31:0] bits;
        draw_bits(2, pick);
        draw_bits(32, bits);
        w = bits;
        if (pick == 0) begin
            draw_bits(3, pick);
            case (pick)
                0:       w = {bits[31], 8'hff, 23'h0};
                1:       w = {bits[31], 8'hff, 1'b0, bits[21:1], 1'b1};
                2:       w = {bits[31], 8'hff, 1'b1, bits[21:0]};
                3:       w = 32'h0000_0000;
                // Minus zero, also the most negative integer
                4:       w = 32'h8000_0000;
                default: w = {bits[31], 8'h00, bits[22:1], 1'b1};
            endcase
        end
    endtask

    always @(posedge clk) begin
        took <= i_valid && o_ready;
    end

    // Inputs change on the falling edge only
    initial begin
        lfsr = 32'he697;
        took = 1'b0;
        sent = 0;
        i_rst = 1'b1;
        i_valid = 1'b0;
        i_ready = 1'b0;
        i_op = '0;
        i_rm = '0;
        i_rs1 = '0;
        i_rs2 = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        i_rst = 1'b0;
        forever begin
            @(negedge clk);
            if (took) begin
                sent++;
            end
            if (sent >= NUM_OPS) begin
                i_valid = 1'b0;
            end else if (!i_valid || took) begin
                draw_bits(3, r);
                i_valid = (r != 0);
                draw_bits(3, r);
                i_op = 3'(r % 6);
                draw_bits(3, r);
                i_rm = (r[1:0] == 2'b11) ? {r[2], 2'b00} : r[2:0];
                make_operand(a);
                make_operand(b);
                // Equal exponents, or the same magnitude with the other sign
                draw_bits(2, r);
                if (r == 0) begin
                    b[30:23] = a[30:23];
                end else if (r == 1) begin
                    b = a ^ 32'h8000_0000;
                end
                i_rs1 = a;
                i_rs2 = b;
            end
            draw_bits(2, r);
            i_ready = (r != 0);
        end
    end

    ////////////////////
    // End of run and timeout
    initial begin
        cycles = 0;
        while (outputs < NUM_OPS && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        // A few idle cycles so a stray extra output is still seen
        repeat (4) @(negedge clk);
        $display("Accepted %0d, checked %0d of %0d, errors %0d",
                 inputs, outputs, NUM_OPS, errors);
        if (outputs < NUM_OPS) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Test failed");
        end else if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
